// ==== hdl/conv_weight_buffer_config.svh ====
`ifndef CONV_WEIGHT_BUFFER_CONFIG_SVH
`define CONV_WEIGHT_BUFFER_CONFIG_SVH

//////////////////////////////////////////////////
// weight word and kernel shape
//////////////////////////////////////////////////

// bits per weight
`define WB_DATA_WIDTH 32

// taps in one 3x3 kernel
`define WB_KERNEL_SIZE 9

// word counter, wide enough for KERNEL_SIZE - 1
`define WB_CNT_WIDTH 4

//////////////////////////////////////////////////
// kernel queue
//////////////////////////////////////////////////

// kernels held, power of two
`define WB_FIFO_DEPTH 16
`define WB_FIFO_ADDR_WIDTH 4

`endif

// ==== hdl/cnn_weight_pkg.sv ====
`default_nettype none

`include "conv_weight_buffer_config.svh"

package cnn_weight_pkg;

	// one kernel, either as a flat storage word or as nine weights
	// tap 0 sits in the lowest bits
	typedef union packed {
		logic [`WB_KERNEL_SIZE*`WB_DATA_WIDTH-1:0] flat;
		logic [`WB_KERNEL_SIZE-1:0][`WB_DATA_WIDTH-1:0] taps;
	} kernel_word_u;

endpackage

`default_nettype wire

// ==== hdl/weight_shift_chain.sv ====
`default_nettype none

`include "conv_weight_buffer_config.svh"

module weight_shift_chain
	import cnn_weight_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      valid_in,
	input  logic [`WB_DATA_WIDTH-1:0] in,
	output kernel_word_u              kernel,
	output logic                      kernel_done
);

	localparam int kernel_size = `WB_KERNEL_SIZE;

	// index of the ninth word of a kernel
	localparam logic [`WB_CNT_WIDTH-1:0] last_word_idx = `WB_CNT_WIDTH'(kernel_size - 1);

	//////////////////////////////////////////////////
	// tap registers
	//////////////////////////////////////////////////

	kernel_word_u taps_q;

	// new word enters at the top tap and walks down toward tap 0
	// after nine words the first one has reached tap 0
	always_ff @(posedge clk) begin
		if (valid_in) begin
			for (int k = 0; k < kernel_size - 1; k++) begin
				taps_q.taps[k] <= taps_q.taps[k + 1];
			end
			taps_q.taps[kernel_size - 1] <= in;
		end
	end

	//////////////////////////////////////////////////
	// word counter
	//////////////////////////////////////////////////

	logic [`WB_CNT_WIDTH-1:0] word_count;
	logic                     last_word;
	logic                     done_q;

	// ninth word of the current kernel is on the input
	assign last_word = valid_in && (word_count == last_word_idx);

	// gaps in valid_in just hold the count
	always_ff @(posedge clk) begin
		if (reset) begin
			word_count <= '0;
		end else if (last_word) begin
			word_count <= '0;
		end else if (valid_in) begin
			word_count <= word_count + 1'b1;
		end
	end

	// done pulse lines up with the edge that shifted in word nine,
	// so the taps are complete while it is high
	always_ff @(posedge clk) begin
		if (reset) begin
			done_q <= 1'b0;
		end else begin
			done_q <= last_word;
		end
	end

	assign kernel      = taps_q;
	assign kernel_done = done_q;

endmodule

`default_nettype wire

// ==== hdl/kernel_fifo.sv ====
`default_nettype none

`include "conv_weight_buffer_config.svh"

module kernel_fifo
	import cnn_weight_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         write,
	input  kernel_word_u kernel_in,
	input  logic         load,
	output kernel_word_u kernel_out,
	output logic         valid_out,
	output logic         full
);

	localparam int depth      = `WB_FIFO_DEPTH;
	localparam int addr_width = `WB_FIFO_ADDR_WIDTH;
	localparam int word_width = `WB_KERNEL_SIZE * `WB_DATA_WIDTH;

	// occupancy needs one more bit than the pointers
	localparam logic [addr_width:0] depth_count = (addr_width + 1)'(depth);

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	logic [word_width-1:0] mem [depth];

	logic [addr_width-1:0] wr_ptr;
	logic [addr_width-1:0] rd_ptr;
	logic [addr_width:0]   count;

	logic full_flag;
	logic empty_flag;
	logic write_accept;
	logic load_accept;

	assign full_flag  = (count == depth_count);
	assign empty_flag = (count == '0);

	// pop only with something stored
	assign load_accept = load && !empty_flag;

	// a full queue still takes a kernel when a pop frees a slot on the same edge
	assign write_accept = write && (!full_flag || load_accept);

	always_ff @(posedge clk) begin
		if (write_accept) begin
			mem[wr_ptr] <= kernel_in.flat;
		end
	end

	//////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (write_accept) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (load_accept) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({write_accept, load_accept})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////

	kernel_word_u out_q;
	logic         valid_q;

	// read sees the old slot contents even when the write hits the same address
	// weights stay on the output until the next accepted load
	always_ff @(posedge clk) begin
		if (reset) begin
			out_q.flat <= '0;
		end else if (load_accept) begin
			out_q.flat <= mem[rd_ptr];
		end
	end

	// one pulse per accepted load
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= load_accept;
		end
	end

	assign kernel_out = out_q;
	assign valid_out  = valid_q;
	assign full       = full_flag;

endmodule

`default_nettype wire

// ==== hdl/conv_weight_buffer.sv ====
`default_nettype none

`include "conv_weight_buffer_config.svh"

module conv_weight_buffer
	import cnn_weight_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      valid_in,
	input  logic [`WB_DATA_WIDTH-1:0] in,
	input  logic                      load_weights,

	output logic [`WB_DATA_WIDTH-1:0] weight_out_00,
	output logic [`WB_DATA_WIDTH-1:0] weight_out_01,
	output logic [`WB_DATA_WIDTH-1:0] weight_out_02,
	output logic [`WB_DATA_WIDTH-1:0] weight_out_03,
	output logic [`WB_DATA_WIDTH-1:0] weight_out_04,
	output logic [`WB_DATA_WIDTH-1:0] weight_out_05,
	output logic [`WB_DATA_WIDTH-1:0] weight_out_06,
	output logic [`WB_DATA_WIDTH-1:0] weight_out_07,
	output logic [`WB_DATA_WIDTH-1:0] weight_out_08,
	output logic                      valid_out,
	output logic                      kernel_full
);

	kernel_word_u kernel;
	logic         kernel_done;
	kernel_word_u kernel_out;

	//////////////////////////////////////////////////
	// shift in and capture
	//////////////////////////////////////////////////

	weight_shift_chain chain_i (
		.clk         (clk),
		.reset       (reset),
		.valid_in    (valid_in),
		.in          (in),
		.kernel      (kernel),
		.kernel_done (kernel_done)
	);

	// source has no ready and should stop sending while kernel_full is high
	kernel_fifo fifo_i (
		.clk        (clk),
		.reset      (reset),
		.write      (kernel_done),
		.kernel_in  (kernel),
		.load       (load_weights),
		.kernel_out (kernel_out),
		.valid_out  (valid_out),
		.full       (kernel_full)
	);

	//////////////////////////////////////////////////
	// weight ports
	//////////////////////////////////////////////////

	// first word of a kernel lands on port 00
	assign weight_out_00 = kernel_out.taps[0];
	assign weight_out_01 = kernel_out.taps[1];
	assign weight_out_02 = kernel_out.taps[2];
	assign weight_out_03 = kernel_out.taps[3];
	assign weight_out_04 = kernel_out.taps[4];
	assign weight_out_05 = kernel_out.taps[5];
	assign weight_out_06 = kernel_out.taps[6];
	assign weight_out_07 = kernel_out.taps[7];
	assign weight_out_08 = kernel_out.taps[8];

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
	parameter real period_ns = 8.0
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	// free running, starts low
	initial begin
		clk = 1'b0;
		forever begin
			#(period_ns / 2.0) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/conv_weight_buffer_checker.sv ====
`default_nettype none

`include "conv_weight_buffer_config.svh"

module conv_weight_buffer_checker (
	input logic                      clk,
	input logic                      reset,
	input logic                      valid_in,
	input logic [`WB_DATA_WIDTH-1:0] in,
	input logic                      load_weights,
	input logic [`WB_DATA_WIDTH-1:0] weight_out_00,
	input logic [`WB_DATA_WIDTH-1:0] weight_out_01,
	input logic [`WB_DATA_WIDTH-1:0] weight_out_02,
	input logic [`WB_DATA_WIDTH-1:0] weight_out_03,
	input logic [`WB_DATA_WIDTH-1:0] weight_out_04,
	input logic [`WB_DATA_WIDTH-1:0] weight_out_05,
	input logic [`WB_DATA_WIDTH-1:0] weight_out_06,
	input logic [`WB_DATA_WIDTH-1:0] weight_out_07,
	input logic [`WB_DATA_WIDTH-1:0] weight_out_08,
	input logic                      valid_out,
	input logic                      kernel_full
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int kernel_size = `WB_KERNEL_SIZE;
	localparam int data_width  = `WB_DATA_WIDTH;
	localparam int depth       = `WB_FIFO_DEPTH;

	int    fail_count = 0;
	string fail_what  = "";

	logic [kernel_size-1:0][data_width-1:0] weight_bus;
	logic [kernel_size-1:0][data_width-1:0] words;
	logic [kernel_size-1:0][data_width-1:0] done_kernel;
	logic [kernel_size-1:0][data_width-1:0] expected_weights;
	logic [kernel_size-1:0][data_width-1:0] shadow [depth];

	logic done_pending;
	logic pop;
	logic push;
	int   word_idx;
	int   head;
	int   tail;
	int   shadow_count = 0;

	// port 00 is the lowest word
	assign weight_bus = {weight_out_08, weight_out_07, weight_out_06, weight_out_05,
		weight_out_04, weight_out_03, weight_out_02, weight_out_01, weight_out_00};

	assign pop  = load_weights && (shadow_count != 0);
	// a pop on the same edge makes room in a full queue
	assign push = done_pending && ((shadow_count < depth) || pop);

	// count failures and keep the latest one
	function automatic void report_failure(input string what);
		fail_count++;
		fail_what = what;
		$error("%s", what);
	endfunction

	//////////////////////////////////////////////////
	// shadow kernel model
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset) begin
			word_idx         <= 0;
			done_pending     <= 1'b0;
			head             <= 0;
			tail             <= 0;
			shadow_count     <= 0;
			expected_weights <= '0;
		end else begin
			done_pending <= 1'b0;
			// first word of a kernel is word 0
			if (valid_in) begin
				words[word_idx] <= in;
				if (word_idx == kernel_size - 1) begin
					done_kernel  <= {in, words[kernel_size-2:0]};
					done_pending <= 1'b1;
					word_idx     <= 0;
				end else begin
					word_idx <= word_idx + 1;
				end
			end
			if (pop) begin
				expected_weights <= shadow[head];
				head             <= (head + 1) % depth;
			end
			if (push) begin
				shadow[tail] <= done_kernel;
				tail         <= (tail + 1) % depth;
			end
			shadow_count <= shadow_count + int'(push) - int'(pop);
		end
	end

	//////////////////////////////////////////////////
	// assertions
	//////////////////////////////////////////////////

	reset_clears_outputs: assert property (@(posedge clk)
		$fell(reset) |-> !valid_out && !kernel_full && (weight_bus == '0))
		else report_failure("outputs not cleared after reset");

	valid_follows_load: assert property (@(posedge clk) disable iff (reset)
		valid_out == $past(pop))
		else report_failure("valid_out does not follow an accepted load");

	popped_kernel_matches: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> (weight_bus == expected_weights))
		else report_failure("weights differ from the oldest queued kernel");

	weights_held: assert property (@(posedge clk) disable iff (reset)
		!valid_out |-> (weight_bus == expected_weights))
		else report_failure("weights changed without an accepted load");

	full_matches_count: assert property (@(posedge clk) disable iff (reset)
		kernel_full == (shadow_count == depth))
		else report_failure("kernel_full does not match the queued kernel count");

endmodule

bind conv_weight_buffer conv_weight_buffer_checker checker_i (.*);

`default_nettype wire

// ==== testbench/conv_weight_buffer_tb.sv ====
`default_nettype none

`include "conv_weight_buffer_config.svh"

module conv_weight_buffer_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int reset_cycles      = 8;
	localparam int rand_seed         = 57092;
	localparam int kernel_size       = `WB_KERNEL_SIZE;
	localparam int full_test_kernels = 20;
	localparam int random_cycles     = 300;
	// stimulus runs roughly 700 cycles
	localparam int cycle_limit       = 2000;

	logic                      clk;
	logic                      reset;
	logic                      valid_in;
	logic [`WB_DATA_WIDTH-1:0] in;
	logic                      load_weights;
	logic [`WB_DATA_WIDTH-1:0] weight_out_00;
	logic [`WB_DATA_WIDTH-1:0] weight_out_01;
	logic [`WB_DATA_WIDTH-1:0] weight_out_02;
	logic [`WB_DATA_WIDTH-1:0] weight_out_03;
	logic [`WB_DATA_WIDTH-1:0] weight_out_04;
	logic [`WB_DATA_WIDTH-1:0] weight_out_05;
	logic [`WB_DATA_WIDTH-1:0] weight_out_06;
	logic [`WB_DATA_WIDTH-1:0] weight_out_07;
	logic [`WB_DATA_WIDTH-1:0] weight_out_08;
	logic                      valid_out;
	logic                      kernel_full;

	int cycle_count = 0;

	tb_clock_gen clock_i (
		.clk (clk)
	);

	conv_weight_buffer conv_weight_buffer_i (
		.clk           (clk),
		.reset         (reset),
		.valid_in      (valid_in),
		.in            (in),
		.load_weights  (load_weights),
		.weight_out_00 (weight_out_00),
		.weight_out_01 (weight_out_01),
		.weight_out_02 (weight_out_02),
		.weight_out_03 (weight_out_03),
		.weight_out_04 (weight_out_04),
		.weight_out_05 (weight_out_05),
		.weight_out_06 (weight_out_06),
		.weight_out_07 (weight_out_07),
		.weight_out_08 (weight_out_08),
		.valid_out     (valid_out),
		.kernel_full   (kernel_full)
	);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		valid_in     = 1'b0;
		load_weights = 1'b0;
		repeat (n) next_cycle();
	endtask

	task automatic send_word(input logic [`WB_DATA_WIDTH-1:0] data, input logic load);
		valid_in     = 1'b1;
		in           = data;
		load_weights = load;
		next_cycle();
		valid_in     = 1'b0;
		load_weights = 1'b0;
	endtask

	task automatic send_kernel(input int max_gap);
		repeat (kernel_size) begin
			send_word($urandom, 1'b0);
			idle_cycles($urandom_range(0, max_gap));
		end
	endtask

	task automatic load_once();
		load_weights = 1'b1;
		next_cycle();
		load_weights = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// failure monitor and timeout
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (conv_weight_buffer_i.checker_i.fail_count != 0) begin
			stop_with_failure($sformatf("FAILED at %t: %s", $realtime,
				conv_weight_buffer_i.checker_i.fail_what));
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			stop_with_failure($sformatf("timeout: stimulus still running after %0d cycles",
				cycle_limit));
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(rand_seed));
		$timeformat(-9, 1, " ns", 0);
		reset        = 1'b1;
		valid_in     = 1'b0;
		in           = '0;
		load_weights = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;

		// kernels with random gaps in valid_in, then popped one by one
		repeat (3) send_kernel(3);
		idle_cycles(2);
		repeat (3) begin
			load_once();
			idle_cycles($urandom_range(0, 2));
		end

		// empty queue, loads are ignored
		repeat (4) begin
			load_once();
			idle_cycles(1);
		end

		// fill past the depth with no loads
		repeat (full_test_kernels) send_kernel(0);
		idle_cycles(2);

		// full queue, each completing kernel meets a load in its done cycle
		repeat (kernel_size) send_word($urandom, 1'b0);
		repeat (3) begin
			send_word($urandom, 1'b1);
			repeat (kernel_size - 1) send_word($urandom, 1'b0);
		end
		load_once();

		// drain, last load hits an empty queue
		repeat (`WB_FIFO_DEPTH + 1) load_once();
		idle_cycles(2);

		// mixed random traffic
		repeat (random_cycles) begin
			valid_in     = ($urandom_range(0, 9) < 6);
			in           = $urandom;
			load_weights = ($urandom_range(0, 9) < 2);
			next_cycle();
		end
		idle_cycles(4);

		if (conv_weight_buffer_i.checker_i.fail_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_with_failure($sformatf("FAILED at %t: %s", $realtime,
				conv_weight_buffer_i.checker_i.fail_what));
		end
	end

endmodule

`default_nettype wire

// ==== conv_weight_buffer.f ====
+incdir+hdl
hdl/cnn_weight_pkg.sv
hdl/weight_shift_chain.sv
hdl/kernel_fifo.sv
hdl/conv_weight_buffer.sv
testbench/tb_clock_gen.sv
testbench/conv_weight_buffer_checker.sv
testbench/conv_weight_buffer_tb.sv
